// ==== logic/net_pkg.sv ====
package net_pkg;

    // ------------------------------------------------------------
    // stream widths
    // ------------------------------------------------------------
    localparam int DATA_W  = 512;
    localparam int KEEP_W  = DATA_W / 8;
    localparam int COUNT_W = 16;

    // ------------------------------------------------------------
    // protocol constants
    // ------------------------------------------------------------
    localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    localparam logic [7:0] IP_PROTO_ICMP = 8'd1;
    localparam logic [7:0] IP_PROTO_UDP  = 8'd17;

    // one beat of a 512-bit stream, byte n in data[8n+7:8n]
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } axis_beat_t;

    // receive branch a frame belongs to
    typedef enum logic [1:0] {
        CLASS_ARP  = 2'd0,
        CLASS_ICMP = 2'd1,
        CLASS_UDP  = 2'd2,
        CLASS_DROP = 2'd3
    } pkt_class_e;

    typedef enum logic [1:0] {
        ST_HEAD    = 2'd0,
        ST_BODY    = 2'd1,
        ST_DISCARD = 2'd2
    } dispatch_state_e;

    // per-class receive packet counts
    typedef struct packed {
        logic [COUNT_W-1:0] arp;
        logic [COUNT_W-1:0] icmp;
        logic [COUNT_W-1:0] udp;
        logic [COUNT_W-1:0] drop;
    } pkt_counts_t;

endpackage

// ==== logic/axis_reg_slice.sv ====
`timescale 1ns/10ps

module axis_reg_slice (
    input  logic                axis_clk,
    input  logic                rst_n,

    input  net_pkg::axis_beat_t s_beat,
    input  logic                s_valid,
    output logic                s_ready,

    output net_pkg::axis_beat_t m_beat,
    output logic                m_valid,
    input  logic                m_ready
);
    import net_pkg::*;

    axis_beat_t skid_beat;
    logic       skid_valid;
    logic       ready_q;
    logic       in_xfer;
    logic       main_free;

    assign in_xfer   = s_valid && ready_q;
    // main register can take a new beat this cycle
    assign main_free = !m_valid || m_ready;
    assign s_ready   = ready_q;

    // ------------------------------------------------------------
    // control state
    // ------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else begin
            if (main_free) begin
                m_valid    <= skid_valid || in_xfer;
                skid_valid <= 1'b0;
            end else if (in_xfer) begin
                skid_valid <= 1'b1;
            end
            // ready next cycle only if the skid register will be empty
            ready_q <= main_free || !(skid_valid || in_xfer);
        end
    end

    // payload, skid drains first to keep order
    always_ff @(posedge axis_clk) begin
        if (main_free) begin
            if (skid_valid) begin
                m_beat <= skid_beat;
            end else if (in_xfer) begin
                m_beat <= s_beat;
            end
        end else if (in_xfer) begin
            skid_beat <= s_beat;
        end
    end

    // registered ready must close before both registers fill
    a_no_overrun: assert property (
        @(posedge axis_clk) disable iff (!rst_n)
        in_xfer |-> !(m_valid && skid_valid)
    );

endmodule

// ==== logic/rx_dispatcher.sv ====
`timescale 1ns/10ps

module rx_dispatcher (
    input  logic                axis_clk,
    input  logic                rst_n,
    input  logic [31:0]         my_ip,

    input  net_pkg::axis_beat_t s_beat,
    input  logic                s_valid,
    output logic                s_ready,

    output net_pkg::axis_beat_t arp_beat,
    output logic                arp_valid,
    input  logic                arp_ready,

    output net_pkg::axis_beat_t icmp_beat,
    output logic                icmp_valid,
    input  logic                icmp_ready,

    output net_pkg::axis_beat_t udp_beat,
    output logic                udp_valid,
    input  logic                udp_ready,

    output logic                pkt_done,
    output net_pkg::pkt_class_e pkt_class
);
    import net_pkg::*;

    dispatch_state_e state;
    pkt_class_e      body_class;
    pkt_class_e      head_class;
    pkt_class_e      cur_class;
    logic [15:0]     ethertype;
    logic [7:0]      ip_proto;
    logic [31:0]     dst_ip;
    logic            xfer;

    // ------------------------------------------------------------
    // header fields, all in the first beat
    // ------------------------------------------------------------
    assign ethertype = {s_beat.data[103:96], s_beat.data[111:104]};
    assign ip_proto  = s_beat.data[191:184];
    assign dst_ip    = {s_beat.data[247:240], s_beat.data[255:248],
                        s_beat.data[263:256], s_beat.data[271:264]};

    always_comb begin
        head_class = CLASS_DROP;
        if (ethertype == ETHERTYPE_ARP) begin
            head_class = CLASS_ARP;
        end else if (ethertype == ETHERTYPE_IPV4 && dst_ip == my_ip) begin
            if (ip_proto == IP_PROTO_ICMP) begin
                head_class = CLASS_ICMP;
            end else if (ip_proto == IP_PROTO_UDP) begin
                head_class = CLASS_UDP;
            end
        end
    end

    // head beat routed on its own decode, rest on the latched class
    always_comb begin
        unique case (state)
            ST_HEAD:    cur_class = head_class;
            ST_BODY:    cur_class = body_class;
            default:    cur_class = CLASS_DROP;
        endcase
    end

    // ------------------------------------------------------------
    // branch outputs
    // ------------------------------------------------------------
    assign arp_beat   = s_beat;
    assign icmp_beat  = s_beat;
    assign udp_beat   = s_beat;
    assign arp_valid  = s_valid && (cur_class == CLASS_ARP);
    assign icmp_valid = s_valid && (cur_class == CLASS_ICMP);
    assign udp_valid  = s_valid && (cur_class == CLASS_UDP);

    always_comb begin
        unique case (cur_class)
            CLASS_ARP:  s_ready = arp_ready;
            CLASS_ICMP: s_ready = icmp_ready;
            CLASS_UDP:  s_ready = udp_ready;
            default:    s_ready = 1'b1;
        endcase
    end

    assign xfer      = s_valid && s_ready;
    assign pkt_done  = xfer && s_beat.last;
    assign pkt_class = cur_class;

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_HEAD;
            body_class <= CLASS_DROP;
        end else if (xfer) begin
            if (s_beat.last) begin
                state <= ST_HEAD;
            end else if (state == ST_HEAD) begin
                body_class <= head_class;
                state      <= (head_class == CLASS_DROP) ? ST_DISCARD : ST_BODY;
            end
        end
    end

    a_one_branch: assert property (
        @(posedge axis_clk) disable iff (!rst_n)
        $onehot0({arp_valid, icmp_valid, udp_valid})
    );

endmodule

// ==== logic/tx_arbiter.sv ====
`timescale 1ns/10ps

module tx_arbiter (
    input  logic                axis_clk,
    input  logic                rst_n,

    input  net_pkg::axis_beat_t ip_beat,
    input  logic                ip_valid,
    output logic                ip_ready,

    input  net_pkg::axis_beat_t arp_beat,
    input  logic                arp_valid,
    output logic                arp_ready,

    output net_pkg::axis_beat_t m_beat,
    output logic                m_valid,
    input  logic                m_ready
);

    // grant_q is 0 for ip, 1 for arp; it also remembers the last winner
    logic busy;
    logic grant_q;
    logic pick;
    logic sel;
    logic m_xfer;

    // ------------------------------------------------------------
    // round-robin pick while idle
    // ------------------------------------------------------------
    always_comb begin
        if (ip_valid && arp_valid) begin
            pick = !grant_q;
        end else begin
            pick = arp_valid;
        end
    end

    assign sel = busy ? grant_q : pick;

    // combinational data path, no added latency
    assign m_beat    = sel ? arp_beat : ip_beat;
    assign m_valid   = sel ? arp_valid : ip_valid;
    assign ip_ready  = m_ready && !sel;
    assign arp_ready = m_ready && sel;
    assign m_xfer    = m_valid && m_ready;

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            grant_q <= 1'b1;
        end else if (!busy) begin
            // lock as soon as a beat is offered, even if stalled
            if (m_valid) begin
                grant_q <= pick;
                busy    <= !(m_xfer && m_beat.last);
            end
        end else if (m_xfer && m_beat.last) begin
            busy <= 1'b0;
        end
    end

    a_grant_held: assert property (
        @(posedge axis_clk) disable iff (!rst_n)
        (m_valid && !(m_xfer && m_beat.last)) |=> (sel == $past(sel))
    );

endmodule

// ==== logic/pkt_counters.sv ====
`timescale 1ns/10ps

module pkt_counters (
    input  logic                 axis_clk,
    input  logic                 rst_n,

    input  logic                 pkt_done,
    input  net_pkg::pkt_class_e  pkt_class,

    output net_pkg::pkt_counts_t counts,
    output logic                 count_vld
);
    import net_pkg::*;

    // ------------------------------------------------------------
    // one wrapping counter per receive class
    // ------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            counts    <= '0;
            count_vld <= 1'b0;
        end else begin
            // strobe lines up with the new count value
            count_vld <= pkt_done;
            if (pkt_done) begin
                unique case (pkt_class)
                    CLASS_ARP: begin
                        counts.arp <= counts.arp + 1'b1;
                    end
                    CLASS_ICMP: begin
                        counts.icmp <= counts.icmp + 1'b1;
                    end
                    CLASS_UDP: begin
                        counts.udp <= counts.udp + 1'b1;
                    end
                    default: begin
                        counts.drop <= counts.drop + 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// ==== logic/network_stack.sv ====
`timescale 1ns/10ps

module network_stack (
    input  logic                 axis_clk,
    input  logic                 rst_n,
    input  logic [31:0]          my_ip,

    // receive link
    input  net_pkg::axis_beat_t  rx_beat,
    input  logic                 rx_valid,
    output logic                 rx_ready,

    // receive branches
    output net_pkg::axis_beat_t  arp_beat,
    output logic                 arp_valid,
    input  logic                 arp_ready,
    output net_pkg::axis_beat_t  icmp_beat,
    output logic                 icmp_valid,
    input  logic                 icmp_ready,
    output net_pkg::axis_beat_t  udp_beat,
    output logic                 udp_valid,
    input  logic                 udp_ready,

    // transmit sources
    input  net_pkg::axis_beat_t  ip_tx_beat,
    input  logic                 ip_tx_valid,
    output logic                 ip_tx_ready,
    input  net_pkg::axis_beat_t  arp_tx_beat,
    input  logic                 arp_tx_valid,
    output logic                 arp_tx_ready,

    // transmit link
    output net_pkg::axis_beat_t  tx_beat,
    output logic                 tx_valid,
    input  logic                 tx_ready,

    output net_pkg::pkt_counts_t counts,
    output logic                 count_vld
);
    import net_pkg::*;

    axis_beat_t rx_s_beat;
    logic       rx_s_valid;
    logic       rx_s_ready;

    axis_beat_t arb_beat;
    logic       arb_valid;
    logic       arb_ready;

    logic       pkt_done;
    pkt_class_e pkt_class;

    // ------------------------------------------------------------
    // receive path
    // ------------------------------------------------------------
    axis_reg_slice u_rx_slice (
        .axis_clk (axis_clk),
        .rst_n    (rst_n),
        .s_beat   (rx_beat),
        .s_valid  (rx_valid),
        .s_ready  (rx_ready),
        .m_beat   (rx_s_beat),
        .m_valid  (rx_s_valid),
        .m_ready  (rx_s_ready)
    );

    rx_dispatcher u_dispatcher (
        .axis_clk   (axis_clk),
        .rst_n      (rst_n),
        .my_ip      (my_ip),
        .s_beat     (rx_s_beat),
        .s_valid    (rx_s_valid),
        .s_ready    (rx_s_ready),
        .arp_beat   (arp_beat),
        .arp_valid  (arp_valid),
        .arp_ready  (arp_ready),
        .icmp_beat  (icmp_beat),
        .icmp_valid (icmp_valid),
        .icmp_ready (icmp_ready),
        .udp_beat   (udp_beat),
        .udp_valid  (udp_valid),
        .udp_ready  (udp_ready),
        .pkt_done   (pkt_done),
        .pkt_class  (pkt_class)
    );

    pkt_counters u_counters (
        .axis_clk  (axis_clk),
        .rst_n     (rst_n),
        .pkt_done  (pkt_done),
        .pkt_class (pkt_class),
        .counts    (counts),
        .count_vld (count_vld)
    );

    // ------------------------------------------------------------
    // transmit path, ip on port 0 and arp on port 1
    // ------------------------------------------------------------
    tx_arbiter u_arbiter (
        .axis_clk  (axis_clk),
        .rst_n     (rst_n),
        .ip_beat   (ip_tx_beat),
        .ip_valid  (ip_tx_valid),
        .ip_ready  (ip_tx_ready),
        .arp_beat  (arp_tx_beat),
        .arp_valid (arp_tx_valid),
        .arp_ready (arp_tx_ready),
        .m_beat    (arb_beat),
        .m_valid   (arb_valid),
        .m_ready   (arb_ready)
    );

    axis_reg_slice u_tx_slice (
        .axis_clk (axis_clk),
        .rst_n    (rst_n),
        .s_beat   (arb_beat),
        .s_valid  (arb_valid),
        .s_ready  (arb_ready),
        .m_beat   (tx_beat),
        .m_valid  (tx_valid),
        .m_ready  (tx_ready)
    );

endmodule

// ==== tests/stack_checker.sv ====
`timescale 1ns/10ps

module stack_checker (
    input  logic                 axis_clk,
    input  logic                 rst_n,

    input  net_pkg::axis_beat_t  arp_beat,
    input  logic                 arp_valid,
    input  logic                 arp_ready,
    input  net_pkg::axis_beat_t  icmp_beat,
    input  logic                 icmp_valid,
    input  logic                 icmp_ready,
    input  net_pkg::axis_beat_t  udp_beat,
    input  logic                 udp_valid,
    input  logic                 udp_ready,

    input  net_pkg::axis_beat_t  tx_beat,
    input  logic                 tx_valid,
    input  logic                 tx_ready,

    input  net_pkg::pkt_counts_t counts,
    input  logic                 count_vld
);
    import net_pkg::*;

    axis_beat_t  exp_arp[$];
    axis_beat_t  exp_icmp[$];
    axis_beat_t  exp_udp[$];
    axis_beat_t  exp_ip_tx[$];
    axis_beat_t  exp_arp_tx[$];
    pkt_class_e  exp_class[$];
    pkt_counts_t model = '0;

    int   err_count    = 0;
    int   test_errs    = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    logic tx_seen      = 1'b0;
    logic tx_in_pkt    = 1'b0;
    logic tx_src       = 1'b0;

    // ------------------------------------------------------------
    // expectations loaded by the testbench
    // ------------------------------------------------------------
    task automatic expect_rx_beat(input pkt_class_e cls, input axis_beat_t b);
        case (cls)
            CLASS_ARP:  exp_arp.push_back(b);
            CLASS_ICMP: exp_icmp.push_back(b);
            default:    exp_udp.push_back(b);
        endcase
    endtask

    task automatic expect_tx_beat(input logic src, input axis_beat_t b);
        if (src) begin
            exp_arp_tx.push_back(b);
        end else begin
            exp_ip_tx.push_back(b);
        end
    endtask

    task automatic expect_frame(input pkt_class_e cls);
        exp_class.push_back(cls);
    endtask

    function automatic int pending();
        return exp_arp.size() + exp_icmp.size() + exp_udp.size() + exp_ip_tx.size()
               + exp_arp_tx.size() + exp_class.size();
    endfunction

    // ------------------------------------------------------------
    // comparisons
    // ------------------------------------------------------------
    task automatic flag_error(input string msg);
        err_count++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic compare_beat(input string name, input axis_beat_t exp, input axis_beat_t got);
        if (exp !== got) begin
            err_count++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_count(input string name, input logic [COUNT_W-1:0] exp,
                                 input logic [COUNT_W-1:0] got);
        if (exp !== got) begin
            err_count++;
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic take_rx_beat(input pkt_class_e cls, input axis_beat_t got);
        axis_beat_t exp;
        string      name;
        logic       empty;
        case (cls)
            CLASS_ARP: begin
                name  = "arp_beat";
                empty = (exp_arp.size() == 0);
                if (!empty) exp = exp_arp.pop_front();
            end
            CLASS_ICMP: begin
                name  = "icmp_beat";
                empty = (exp_icmp.size() == 0);
                if (!empty) exp = exp_icmp.pop_front();
            end
            default: begin
                name  = "udp_beat";
                empty = (exp_udp.size() == 0);
                if (!empty) exp = exp_udp.pop_front();
            end
        endcase
        if (empty) begin
            flag_error($sformatf("a beat appeared on %s that no frame should send there", name));
        end else begin
            compare_beat(name, exp, got);
        end
    endtask

    // byte 0 of every transmit beat tags its source
    task automatic take_tx_beat(input axis_beat_t got);
        axis_beat_t exp;
        logic       src;
        logic       empty;
        src = got.data[0];
        if (!tx_seen && src) begin
            flag_error("the first transmit packet after reset did not come from ip_tx");
        end
        if (tx_in_pkt && src != tx_src) begin
            flag_error("two transmit packets were interleaved on tx");
        end
        tx_seen   = 1'b1;
        tx_src    = src;
        tx_in_pkt = !got.last;
        if (src) begin
            empty = (exp_arp_tx.size() == 0);
            if (!empty) exp = exp_arp_tx.pop_front();
        end else begin
            empty = (exp_ip_tx.size() == 0);
            if (!empty) exp = exp_ip_tx.pop_front();
        end
        if (empty) begin
            flag_error("a beat left tx that no transmit source had sent");
        end else begin
            compare_beat("tx_beat", exp, got);
        end
    endtask

    task automatic check_counts();
        pkt_class_e cls;
        if (exp_class.size() == 0) begin
            flag_error("count_vld pulsed with no frame outstanding");
        end else begin
            cls = exp_class.pop_front();
            case (cls)
                CLASS_ARP:  model.arp  = model.arp + 1'b1;
                CLASS_ICMP: model.icmp = model.icmp + 1'b1;
                CLASS_UDP:  model.udp  = model.udp + 1'b1;
                default:    model.drop = model.drop + 1'b1;
            endcase
            compare_count("counts.arp", model.arp, counts.arp);
            compare_count("counts.icmp", model.icmp, counts.icmp);
            compare_count("counts.udp", model.udp, counts.udp);
            compare_count("counts.drop", model.drop, counts.drop);
        end
    endtask

    // ------------------------------------------------------------
    // monitor, transfers happen on the rising edge
    // ------------------------------------------------------------
    always @(posedge axis_clk) begin
        if (rst_n) begin
            if (arp_valid && arp_ready) take_rx_beat(CLASS_ARP, arp_beat);
            if (icmp_valid && icmp_ready) take_rx_beat(CLASS_ICMP, icmp_beat);
            if (udp_valid && udp_ready) take_rx_beat(CLASS_UDP, udp_beat);
            if (tx_valid && tx_ready) take_tx_beat(tx_beat);
            if (count_vld) check_counts();
        end
    end

    // ------------------------------------------------------------
    // test bookkeeping
    // ------------------------------------------------------------
    task automatic close_test(input string name);
        tests_run++;
        if (err_count == test_errs) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    task automatic print_totals();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
    endtask

endmodule

// ==== tests/tb_network_stack.sv ====
`timescale 1ns/10ps

module tb_network_stack;
    import net_pkg::*;

    localparam int          N_FRAMES   = 10;
    localparam int          N_TX       = 6;
    localparam int          WAIT_LIMIT = 400;
    localparam logic [31:0] MY_IP      = 32'hC0A8_0A05;
    localparam logic [31:0] OTHER_IP   = 32'hC0A8_0A63;

    typedef struct packed {
        logic [15:0]       ethertype;
        logic [7:0]        proto;
        logic              to_me;
        logic [2:0]        beats;
        logic [KEEP_W-1:0] last_keep;
        logic              stall;
        pkt_class_e        exp_class;
    } frame_entry_t;

    typedef struct packed {
        logic       src;
        logic [2:0] beats;
    } tx_entry_t;

    logic        axis_clk = 1'b0;
    logic        rst_n;
    logic [31:0] my_ip;
    axis_beat_t  rx_beat, arp_beat, icmp_beat, udp_beat;
    axis_beat_t  ip_tx_beat, arp_tx_beat, tx_beat;
    logic        rx_valid, rx_ready, arp_valid, arp_ready, icmp_valid, icmp_ready;
    logic        udp_valid, udp_ready, ip_tx_valid, ip_tx_ready, arp_tx_valid, arp_tx_ready;
    logic        tx_valid, tx_ready, count_vld;
    pkt_counts_t counts;

    frame_entry_t frame_tab [N_FRAMES];
    tx_entry_t    tx_tab [N_TX];
    axis_beat_t   ip_tx_q[$];
    axis_beat_t   arp_tx_q[$];
    logic [31:0]  rng_state = 32'd94764;

    always #4 axis_clk = ~axis_clk;

    network_stack u_dut (.*);

    stack_checker u_checker (.*);

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic load_tables();
        // ethertype, protocol, to my_ip, beats, last keep, udp stall, expected class
        frame_tab[0] = {16'h0806, 8'd0, 1'b1, 3'd1, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, CLASS_ARP};
        frame_tab[1] = {16'h0800, 8'd1, 1'b1, 3'd2, 64'h0000_0000_0000_00FF, 1'b0, CLASS_ICMP};
        frame_tab[2] = {16'h0800, 8'd17, 1'b1, 3'd3, 64'h0000_0000_FFFF_FFFF, 1'b0, CLASS_UDP};
        frame_tab[3] = {16'h0800, 8'd17, 1'b0, 3'd2, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, CLASS_DROP};
        frame_tab[4] = {16'h0800, 8'd6, 1'b1, 3'd1, 64'h0000_003F_FFFF_FFFF, 1'b0, CLASS_DROP};
        frame_tab[5] = {16'h86DD, 8'd17, 1'b1, 3'd3, 64'h0000_0000_0000_0001, 1'b0, CLASS_DROP};
        frame_tab[6] = {16'h0806, 8'd0, 1'b0, 3'd4, 64'h0000_0000_0000_000F, 1'b0, CLASS_ARP};
        frame_tab[7] = {16'h0800, 8'd1, 1'b1, 3'd4, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, CLASS_ICMP};
        frame_tab[8] = {16'h0800, 8'd17, 1'b1, 3'd4, 64'h0000_0000_00FF_FFFF, 1'b1, CLASS_UDP};
        frame_tab[9] = {16'h0800, 8'd17, 1'b1, 3'd1, 64'h0000_003F_FFFF_FFFF, 1'b0, CLASS_UDP};
        // source (0 ip, 1 arp), beats
        tx_tab[0] = {1'b0, 3'd2};
        tx_tab[1] = {1'b1, 3'd1};
        tx_tab[2] = {1'b0, 3'd1};
        tx_tab[3] = {1'b1, 3'd3};
        tx_tab[4] = {1'b0, 3'd3};
        tx_tab[5] = {1'b1, 3'd2};
    endtask

    task automatic abort_run(input string reason);
        $display("timeout at %0t: %s", $time, reason);
        $display("Test failed");
        $finish;
    endtask

    // ------------------------------------------------------------
    // frame building and receive stimulus
    // ------------------------------------------------------------
    function automatic axis_beat_t frame_beat(input frame_entry_t f, input int idx);
        axis_beat_t  b;
        logic [31:0] dst;
        int          w;
        for (w = 0; w < DATA_W / 32; w++) begin
            b.data[32*w +: 32] = next_random();
        end
        b.last = (idx == f.beats - 1);
        b.keep = b.last ? f.last_keep : '1;
        if (idx == 0) begin
            // network byte order, byte n at bits 8n+7:8n
            dst = f.to_me ? MY_IP : OTHER_IP;
            b.data[8*12 +: 8] = f.ethertype[15:8];
            b.data[8*13 +: 8] = f.ethertype[7:0];
            b.data[8*23 +: 8] = f.proto;
            b.data[8*30 +: 8] = dst[31:24];
            b.data[8*31 +: 8] = dst[23:16];
            b.data[8*32 +: 8] = dst[15:8];
            b.data[8*33 +: 8] = dst[7:0];
        end
        return b;
    endfunction

    task automatic send_rx_beat(input axis_beat_t b);
        int guard;
        guard    = 0;
        rx_beat  = b;
        rx_valid = 1'b1;
        @(posedge axis_clk);
        while (!rx_ready) begin
            guard++;
            if (guard > WAIT_LIMIT) abort_run("rx_ready stayed low");
            @(posedge axis_clk);
        end
        @(negedge axis_clk);
    endtask

    // stall the udp branch once its first beat has gone through
    task automatic hold_udp_ready(input int len);
        int guard;
        guard = 0;
        @(posedge axis_clk);
        while (!(udp_valid && udp_ready)) begin
            guard++;
            if (guard > WAIT_LIMIT) abort_run("no UDP beat arrived before the stall");
            @(posedge axis_clk);
        end
        @(negedge axis_clk);
        udp_ready = 1'b0;
        repeat (len) @(negedge axis_clk);
        udp_ready = 1'b1;
    endtask

    task automatic wait_idle();
        int guard;
        guard = 0;
        while (u_checker.pending() != 0) begin
            guard++;
            if (guard > WAIT_LIMIT) abort_run("expected outputs never arrived");
            @(negedge axis_clk);
        end
        // room for any stray beat or strobe to show up
        repeat (3) @(negedge axis_clk);
    endtask

    task automatic run_frame(input int n);
        frame_entry_t f;
        axis_beat_t   b;
        int           i;
        int           stall_len;
        f         = frame_tab[n];
        stall_len = 0;
        if (f.stall) stall_len = 2 + int'(next_random() % 8);
        u_checker.expect_frame(f.exp_class);
        fork
            begin
                for (i = 0; i < f.beats; i++) begin
                    b = frame_beat(f, i);
                    if (f.exp_class != CLASS_DROP) u_checker.expect_rx_beat(f.exp_class, b);
                    send_rx_beat(b);
                end
                rx_valid = 1'b0;
            end
            begin
                if (f.stall) hold_udp_ready(stall_len);
            end
        join
        wait_idle();
        u_checker.close_test($sformatf("frame %0d class %0d", n, f.exp_class));
    endtask

    // ------------------------------------------------------------
    // transmit stimulus
    // ------------------------------------------------------------
    task automatic drive_tx_beat(input logic src, input axis_beat_t b);
        int guard;
        guard = 0;
        if (src) begin
            arp_tx_beat  = b;
            arp_tx_valid = 1'b1;
        end else begin
            ip_tx_beat  = b;
            ip_tx_valid = 1'b1;
        end
        @(posedge axis_clk);
        while (!(src ? arp_tx_ready : ip_tx_ready)) begin
            guard++;
            if (guard > WAIT_LIMIT) abort_run("a transmit source was never served");
            @(posedge axis_clk);
        end
        @(negedge axis_clk);
        if (src) begin
            arp_tx_valid = 1'b0;
        end else begin
            ip_tx_valid = 1'b0;
        end
    endtask

    task automatic run_tx(input logic backpressure, input string name);
        axis_beat_t  b;
        logic [31:0] r;
        logic        ip_done;
        logic        arp_done;
        int          n, j, w, guard;
        for (n = 0; n < N_TX; n++) begin
            for (j = 0; j < tx_tab[n].beats; j++) begin
                for (w = 0; w < DATA_W / 32; w++) begin
                    b.data[32*w +: 32] = next_random();
                end
                r            = next_random();
                b.data[7:0]  = {7'd0, tx_tab[n].src};
                b.data[15:8] = n[7:0];
                b.last       = (j == tx_tab[n].beats - 1);
                b.keep       = b.last ? {32'd0, r | 32'd1} : '1;
                u_checker.expect_tx_beat(tx_tab[n].src, b);
                if (tx_tab[n].src) begin
                    arp_tx_q.push_back(b);
                end else begin
                    ip_tx_q.push_back(b);
                end
            end
        end
        ip_done  = 1'b0;
        arp_done = 1'b0;
        guard    = 0;
        // both sources start on the same edge
        fork
            begin
                while (ip_tx_q.size() > 0) begin
                    drive_tx_beat(1'b0, ip_tx_q.pop_front());
                end
                ip_done = 1'b1;
            end
            begin
                while (arp_tx_q.size() > 0) begin
                    drive_tx_beat(1'b1, arp_tx_q.pop_front());
                end
                arp_done = 1'b1;
            end
            begin
                while (backpressure && !(ip_done && arp_done) && guard < 20 * WAIT_LIMIT) begin
                    @(negedge axis_clk);
                    r        = next_random();
                    tx_ready = |r[1:0];
                    guard++;
                end
            end
        join
        tx_ready = 1'b1;
        wait_idle();
        u_checker.close_test(name);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int n;
        rst_n        = 1'b0;
        my_ip        = MY_IP;
        rx_beat      = '0;
        rx_valid     = 1'b0;
        arp_ready    = 1'b1;
        icmp_ready   = 1'b1;
        udp_ready    = 1'b1;
        ip_tx_beat   = '0;
        ip_tx_valid  = 1'b0;
        arp_tx_beat  = '0;
        arp_tx_valid = 1'b0;
        tx_ready     = 1'b1;
        load_tables();
        repeat (4) @(negedge axis_clk);
        rst_n = 1'b1;
        repeat (2) @(negedge axis_clk);
        for (n = 0; n < N_FRAMES; n++) begin
            run_frame(n);
        end
        run_tx(1'b0, "transmit merge");
        run_tx(1'b1, "transmit back-pressure");
        u_checker.print_totals();
        if (u_checker.err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/net_pkg.sv
logic/axis_reg_slice.sv
logic/rx_dispatcher.sv
logic/tx_arbiter.sv
logic/pkt_counters.sv
logic/network_stack.sv
tests/stack_checker.sv
tests/tb_network_stack.sv
